//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := tb_nand_ctrl
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
+incdir+.
nand_ctrl_pkg.sv
nand_cmd_decode.sv
nand_wait_timer.sv
nand_seq_fsm.sv
nand_ctrl_top.sv
tb_nand_flash_model.sv
tb_nand_ctrl.sv

//--- nand_cmd_decode.sv
`include "nand_ctrl_config.svh"

module nand_cmd_decode (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        start_i,
  input  logic [`NC_HOST_CMD_W-1:0]   command_i,
  output nand_ctrl_pkg::op_e          op_o,
  output logic                        id_six_byte_o
);

  localparam logic [`NC_HOST_CMD_W-1:0] HOST_RESET =
    {`NC_CMD_RESET, {`NC_FLASH_CMD_W{1'b0}}};
  localparam logic [`NC_HOST_CMD_W-1:0] HOST_STATUS =
    {`NC_CMD_STATUS, {`NC_FLASH_CMD_W{1'b0}}};
  localparam logic [`NC_HOST_CMD_W-1:0] HOST_ERASE =
    {`NC_CMD_ERASE_SETUP, `NC_CMD_ERASE_CONFIRM};

  nand_ctrl_pkg::op_e op_class;

  // read id only looks at the upper byte
  always_comb begin
    op_class = nand_ctrl_pkg::OP_NONE;
    if (command_i == HOST_RESET) begin
      op_class = nand_ctrl_pkg::OP_RESET;
    end else if (command_i == HOST_STATUS) begin
      op_class = nand_ctrl_pkg::OP_STATUS;
    end else if (command_i[`NC_HOST_CMD_W-1 -: `NC_FLASH_CMD_W] == `NC_CMD_READ_ID) begin
      op_class = nand_ctrl_pkg::OP_READ_ID;
    end else if (command_i == HOST_ERASE) begin
      op_class = nand_ctrl_pkg::OP_ERASE;
    end
  end

  // held for one cycle after the start strobe only
  always_ff @(posedge clk) begin
    if (!rstn) begin
      op_o          <= nand_ctrl_pkg::OP_NONE;
      id_six_byte_o <= 1'b0;
    end else if (start_i) begin
      op_o          <= op_class;
      id_six_byte_o <= command_i[5];
    end else begin
      op_o          <= nand_ctrl_pkg::OP_NONE;
      id_six_byte_o <= 1'b0;
    end
  end

endmodule

//--- nand_ctrl_config.svh
`ifndef NAND_CTRL_CONFIG_SVH
`define NAND_CTRL_CONFIG_SVH

// widths
`define NC_HOST_CMD_W        16
`define NC_FLASH_CMD_W       8
`define NC_REG_ADDR_W        12

// wait lengths in clock cycles
`define NC_TCLR_CYCLES       4
`define NC_TWB_CYCLES        6
`define NC_WAIT_CNT_W        4

// buffer register map
`define NC_ID_REG_BASE       12'h800
`define NC_STATUS_REG_ADDR   12'h806

// flash command bytes
`define NC_CMD_RESET         8'hFF
`define NC_CMD_STATUS        8'h70
`define NC_CMD_READ_ID       8'h90
`define NC_CMD_ERASE_SETUP   8'h60
`define NC_CMD_ERASE_CONFIRM 8'hD0
`define NC_CMD_ID_ADDR       8'h00

`endif

//--- nand_ctrl_pkg.sv
package nand_ctrl_pkg;

  //////////////////////////////
  // host operation class
  //////////////////////////////
  typedef enum logic [2:0] {
    OP_NONE    = 3'd0,
    OP_RESET   = 3'd1,
    OP_STATUS  = 3'd2,
    OP_READ_ID = 3'd3,
    OP_ERASE   = 3'd4
  } op_e;

  //////////////////////////////
  // sequencer states
  //////////////////////////////
  typedef enum logic [4:0] {
    S_IDLE,
    // device reset
    S_RST_CMD, S_RST_TGL, S_RST_CLR, S_RST_WAIT, S_RST_BUSY,
    // read status
    S_STA_CMD, S_STA_TGL, S_STA_CLR, S_STA_WAIT, S_STA_READ,
    // read id
    S_ID_CMD, S_ID_TGL, S_ID_ADDR_CMD, S_ID_ADDR_TGL, S_ID_READ,
    // block erase
    S_ERS_CMD, S_ERS_TGL, S_ERS_ROW1, S_ERS_ROW2, S_ERS_ROW3,
    S_ERS_CFM_CMD, S_ERS_CFM_TGL, S_ERS_CLR, S_ERS_WAIT, S_ERS_BUSY,
    // shared end of operation
    S_DONE
  } state_e;

  // cycle kind for the toggle controller
  typedef enum logic [2:0] {
    TG_CMD      = 3'b000,
    TG_ADDR     = 3'b001,
    TG_REG_READ = 3'b010
  } toggle_code_e;

  // flash bus source
  typedef enum logic [1:0] {
    CAD_CMD  = 2'b11,
    CAD_ADDR = 2'b10
  } cad_sel_e;

  // row address byte select
  typedef enum logic [2:0] {
    AMUX_ROW1 = 3'b010,
    AMUX_ROW2 = 3'b011,
    AMUX_ROW3 = 3'b100
  } amux_sel_e;

endpackage

//--- nand_ctrl_top.sv
`include "nand_ctrl_config.svh"

module nand_ctrl_top (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          start_i,
  input  logic [`NC_HOST_CMD_W-1:0]     command_i,
  input  logic                          address_num_i,
  input  logic                          r_nb_i,
  input  logic                          toggle_done_i,
  output logic                          toggle_en_o,
  output nand_ctrl_pkg::toggle_code_e   cmd_code_o,
  output logic [`NC_FLASH_CMD_W-1:0]    cmd_o,
  output logic                          cmd_en_o,
  output logic                          radr_en_o,
  output nand_ctrl_pkg::cad_sel_e       cad_sel_o,
  output nand_ctrl_pkg::amux_sel_e      amux_sel_o,
  output logic [`NC_REG_ADDR_W-1:0]     bf_reg_addr_o,
  output logic                          op_done_o
);

  nand_ctrl_pkg::op_e op;
  logic               id_six_byte;
  logic               wait_clr;
  logic               wait_en;
  logic               tclr_done;
  logic               twb_done;

  nand_cmd_decode u_decode (
    .clk           (clk),
    .rstn          (rstn),
    .start_i       (start_i),
    .command_i     (command_i),
    .op_o          (op),
    .id_six_byte_o (id_six_byte)
  );

  nand_wait_timer u_timer (
    .clk         (clk),
    .rstn        (rstn),
    .wait_clr_i  (wait_clr),
    .wait_en_i   (wait_en),
    .tclr_done_o (tclr_done),
    .twb_done_o  (twb_done)
  );

  nand_seq_fsm u_seq (
    .clk           (clk),
    .rstn          (rstn),
    .op_i          (op),
    .id_six_byte_i (id_six_byte),
    .address_num_i (address_num_i),
    .r_nb_i        (r_nb_i),
    .toggle_done_i (toggle_done_i),
    .tclr_done_i   (tclr_done),
    .twb_done_i    (twb_done),
    .wait_clr_o    (wait_clr),
    .wait_en_o     (wait_en),
    .toggle_en_o   (toggle_en_o),
    .cmd_code_o    (cmd_code_o),
    .cmd_o         (cmd_o),
    .cmd_en_o      (cmd_en_o),
    .radr_en_o     (radr_en_o),
    .cad_sel_o     (cad_sel_o),
    .amux_sel_o    (amux_sel_o),
    .bf_reg_addr_o (bf_reg_addr_o),
    .op_done_o     (op_done_o)
  );

endmodule

//--- nand_seq_fsm.sv
`include "nand_ctrl_config.svh"

module nand_seq_fsm (
  input  logic                          clk,
  input  logic                          rstn,
  input  nand_ctrl_pkg::op_e            op_i,
  input  logic                          id_six_byte_i,
  input  logic                          address_num_i,
  input  logic                          r_nb_i,
  input  logic                          toggle_done_i,
  input  logic                          tclr_done_i,
  input  logic                          twb_done_i,
  output logic                          wait_clr_o,
  output logic                          wait_en_o,
  output logic                          toggle_en_o,
  output nand_ctrl_pkg::toggle_code_e   cmd_code_o,
  output logic [`NC_FLASH_CMD_W-1:0]    cmd_o,
  output logic                          cmd_en_o,
  output logic                          radr_en_o,
  output nand_ctrl_pkg::cad_sel_e       cad_sel_o,
  output nand_ctrl_pkg::amux_sel_e      amux_sel_o,
  output logic [`NC_REG_ADDR_W-1:0]     bf_reg_addr_o,
  output logic                          op_done_o
);

  nand_ctrl_pkg::state_e state_q;
  nand_ctrl_pkg::state_e state_d;
  logic                  six_byte_q;
  logic [2:0]            id_idx_q;
  logic [2:0]            id_last;

  assign id_last = six_byte_q ? 3'd5 : 3'd3;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q <= nand_ctrl_pkg::S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // id length and byte index, set up while idle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      six_byte_q <= 1'b0;
      id_idx_q   <= 3'd0;
    end else if (state_q == nand_ctrl_pkg::S_IDLE) begin
      six_byte_q <= id_six_byte_i;
      id_idx_q   <= 3'd0;
    end else if ((state_q == nand_ctrl_pkg::S_ID_READ) && toggle_done_i) begin
      id_idx_q <= id_idx_q + 3'd1;
    end
  end

  always_comb begin
    state_d       = state_q;
    wait_clr_o    = 1'b0;
    wait_en_o     = 1'b0;
    toggle_en_o   = 1'b0;
    cmd_code_o    = nand_ctrl_pkg::TG_CMD;
    cmd_o         = '0;
    cmd_en_o      = 1'b0;
    radr_en_o     = 1'b0;
    cad_sel_o     = nand_ctrl_pkg::CAD_CMD;
    amux_sel_o    = nand_ctrl_pkg::AMUX_ROW1;
    bf_reg_addr_o = '0;
    op_done_o     = 1'b0;
    case (state_q)
      // op_i is only valid the cycle after start
      nand_ctrl_pkg::S_IDLE: begin
        case (op_i)
          nand_ctrl_pkg::OP_RESET:   state_d = nand_ctrl_pkg::S_RST_CMD;
          nand_ctrl_pkg::OP_STATUS:  state_d = nand_ctrl_pkg::S_STA_CMD;
          nand_ctrl_pkg::OP_READ_ID: state_d = nand_ctrl_pkg::S_ID_CMD;
          nand_ctrl_pkg::OP_ERASE:   state_d = nand_ctrl_pkg::S_ERS_CMD;
          default:                   state_d = nand_ctrl_pkg::S_IDLE;
        endcase
      end

      //////////////////////////////
      // device reset
      //////////////////////////////
      nand_ctrl_pkg::S_RST_CMD: begin
        cmd_o    = `NC_CMD_RESET;
        cmd_en_o = 1'b1;
        state_d  = nand_ctrl_pkg::S_RST_TGL;
      end
      nand_ctrl_pkg::S_RST_TGL: begin
        toggle_en_o = 1'b1;
        if (toggle_done_i) state_d = nand_ctrl_pkg::S_RST_CLR;
      end
      nand_ctrl_pkg::S_RST_CLR: begin
        wait_clr_o = 1'b1;
        state_d    = nand_ctrl_pkg::S_RST_WAIT;
      end
      // tWB before busy is valid
      nand_ctrl_pkg::S_RST_WAIT: begin
        wait_en_o = 1'b1;
        if (twb_done_i) state_d = nand_ctrl_pkg::S_RST_BUSY;
      end
      nand_ctrl_pkg::S_RST_BUSY: begin
        if (r_nb_i) state_d = nand_ctrl_pkg::S_DONE;
      end

      //////////////////////////////
      // read status
      //////////////////////////////
      nand_ctrl_pkg::S_STA_CMD: begin
        cmd_o    = `NC_CMD_STATUS;
        cmd_en_o = 1'b1;
        state_d  = nand_ctrl_pkg::S_STA_TGL;
      end
      nand_ctrl_pkg::S_STA_TGL: begin
        toggle_en_o = 1'b1;
        if (toggle_done_i) state_d = nand_ctrl_pkg::S_STA_CLR;
      end
      nand_ctrl_pkg::S_STA_CLR: begin
        wait_clr_o = 1'b1;
        state_d    = nand_ctrl_pkg::S_STA_WAIT;
      end
      nand_ctrl_pkg::S_STA_WAIT: begin
        wait_en_o = 1'b1;
        if (tclr_done_i) state_d = nand_ctrl_pkg::S_STA_READ;
      end
      nand_ctrl_pkg::S_STA_READ: begin
        toggle_en_o   = 1'b1;
        cmd_code_o    = nand_ctrl_pkg::TG_REG_READ;
        bf_reg_addr_o = `NC_STATUS_REG_ADDR;
        if (toggle_done_i) state_d = nand_ctrl_pkg::S_DONE;
      end

      //////////////////////////////
      // read id
      //////////////////////////////
      nand_ctrl_pkg::S_ID_CMD: begin
        cmd_o    = `NC_CMD_READ_ID;
        cmd_en_o = 1'b1;
        state_d  = nand_ctrl_pkg::S_ID_TGL;
      end
      nand_ctrl_pkg::S_ID_TGL: begin
        toggle_en_o = 1'b1;
        if (toggle_done_i) state_d = nand_ctrl_pkg::S_ID_ADDR_CMD;
      end
      nand_ctrl_pkg::S_ID_ADDR_CMD: begin
        cmd_o    = `NC_CMD_ID_ADDR;
        cmd_en_o = 1'b1;
        state_d  = nand_ctrl_pkg::S_ID_ADDR_TGL;
      end
      // id address byte comes from the command latch
      nand_ctrl_pkg::S_ID_ADDR_TGL: begin
        toggle_en_o = 1'b1;
        cmd_code_o  = nand_ctrl_pkg::TG_ADDR;
        if (toggle_done_i) state_d = nand_ctrl_pkg::S_ID_READ;
      end
      nand_ctrl_pkg::S_ID_READ: begin
        toggle_en_o   = 1'b1;
        cmd_code_o    = nand_ctrl_pkg::TG_REG_READ;
        bf_reg_addr_o = `NC_ID_REG_BASE + {{(`NC_REG_ADDR_W-3){1'b0}}, id_idx_q};
        if (toggle_done_i && (id_idx_q == id_last)) state_d = nand_ctrl_pkg::S_DONE;
      end

      //////////////////////////////
      // block erase
      //////////////////////////////
      nand_ctrl_pkg::S_ERS_CMD: begin
        cmd_o     = `NC_CMD_ERASE_SETUP;
        cmd_en_o  = 1'b1;
        radr_en_o = 1'b1;
        state_d   = nand_ctrl_pkg::S_ERS_TGL;
      end
      nand_ctrl_pkg::S_ERS_TGL: begin
        toggle_en_o = 1'b1;
        if (toggle_done_i) state_d = nand_ctrl_pkg::S_ERS_ROW1;
      end
      nand_ctrl_pkg::S_ERS_ROW1: begin
        toggle_en_o = 1'b1;
        cmd_code_o  = nand_ctrl_pkg::TG_ADDR;
        cad_sel_o   = nand_ctrl_pkg::CAD_ADDR;
        if (toggle_done_i) state_d = nand_ctrl_pkg::S_ERS_ROW2;
      end
      // third row cycle only for larger parts
      nand_ctrl_pkg::S_ERS_ROW2: begin
        toggle_en_o = 1'b1;
        cmd_code_o  = nand_ctrl_pkg::TG_ADDR;
        cad_sel_o   = nand_ctrl_pkg::CAD_ADDR;
        amux_sel_o  = nand_ctrl_pkg::AMUX_ROW2;
        if (toggle_done_i) begin
          state_d = address_num_i ? nand_ctrl_pkg::S_ERS_ROW3 : nand_ctrl_pkg::S_ERS_CFM_CMD;
        end
      end
      nand_ctrl_pkg::S_ERS_ROW3: begin
        toggle_en_o = 1'b1;
        cmd_code_o  = nand_ctrl_pkg::TG_ADDR;
        cad_sel_o   = nand_ctrl_pkg::CAD_ADDR;
        amux_sel_o  = nand_ctrl_pkg::AMUX_ROW3;
        if (toggle_done_i) state_d = nand_ctrl_pkg::S_ERS_CFM_CMD;
      end
      nand_ctrl_pkg::S_ERS_CFM_CMD: begin
        cmd_o    = `NC_CMD_ERASE_CONFIRM;
        cmd_en_o = 1'b1;
        state_d  = nand_ctrl_pkg::S_ERS_CFM_TGL;
      end
      nand_ctrl_pkg::S_ERS_CFM_TGL: begin
        toggle_en_o = 1'b1;
        if (toggle_done_i) state_d = nand_ctrl_pkg::S_ERS_CLR;
      end
      nand_ctrl_pkg::S_ERS_CLR: begin
        wait_clr_o = 1'b1;
        state_d    = nand_ctrl_pkg::S_ERS_WAIT;
      end
      nand_ctrl_pkg::S_ERS_WAIT: begin
        wait_en_o = 1'b1;
        if (twb_done_i) state_d = nand_ctrl_pkg::S_ERS_BUSY;
      end
      // erase result is fetched with a status read
      nand_ctrl_pkg::S_ERS_BUSY: begin
        if (r_nb_i) state_d = nand_ctrl_pkg::S_STA_CMD;
      end

      nand_ctrl_pkg::S_DONE: begin
        op_done_o = 1'b1;
        state_d   = nand_ctrl_pkg::S_IDLE;
      end
      default: state_d = nand_ctrl_pkg::S_IDLE;
    endcase
  end

endmodule

//--- nand_wait_timer.sv
`include "nand_ctrl_config.svh"

module nand_wait_timer (
  input  logic clk,
  input  logic rstn,
  input  logic wait_clr_i,
  input  logic wait_en_i,
  output logic tclr_done_o,
  output logic twb_done_o
);

  logic [`NC_WAIT_CNT_W-1:0] cnt_q;
  logic [`NC_WAIT_CNT_W:0]   cnt_incl;

  // count including the current enabled cycle
  assign cnt_incl = {1'b0, cnt_q} + 1'b1;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt_q <= '0;
    end else if (wait_clr_i) begin
      cnt_q <= '0;
    end else if (wait_en_i && (cnt_q != {`NC_WAIT_CNT_W{1'b1}})) begin
      // saturate at the top
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // done in the last enabled cycle of each wait
  assign tclr_done_o = wait_en_i && (cnt_incl >= `NC_TCLR_CYCLES);
  assign twb_done_o  = wait_en_i && (cnt_incl >= `NC_TWB_CYCLES);

endmodule

//--- tb_nand_ctrl.sv
`include "nand_ctrl_config.svh"

module tb_nand_ctrl;
  timeunit 1ns;
  timeprecision 100ps;

  // room for ten operations of up to 100 cycles plus idle gaps
  localparam int MAX_CYCLES = 3000;

  // step select holds the bus source, the source with the row byte, or the register address
  localparam logic [11:0] SEL_CMD  = 12'h003;
  localparam logic [11:0] SEL_ROW1 = 12'h012;
  localparam logic [11:0] SEL_ROW2 = 12'h013;
  localparam logic [11:0] SEL_ROW3 = 12'h014;

  // toggle step as {cycle kind, select, last command byte}
  typedef logic [22:0] step_t;

  logic                           clk;
  logic                           rstn;
  logic                           start;
  logic [`NC_HOST_CMD_W-1:0]      command;
  logic                           address_num;
  logic                           r_nb;
  logic                           toggle_done;
  logic                           toggle_en;
  nand_ctrl_pkg::toggle_code_e    cmd_code;
  logic [`NC_FLASH_CMD_W-1:0]     cmd;
  logic                           cmd_en;
  logic                           radr_en;
  nand_ctrl_pkg::cad_sel_e        cad_sel;
  nand_ctrl_pkg::amux_sel_e       amux_sel;
  logic [`NC_REG_ADDR_W-1:0]      bf_reg_addr;
  logic                           op_done;

  step_t                          got_q[$];
  step_t                          exp_q[$];
  int                             errors = 0;
  int                             tests = 0;
  int                             failed = 0;
  int                             cyc = 0;
  int                             done_cnt;
  int                             cmd_en_cnt;
  int                             radr_cnt;
  int                             en_cycles;
  int                             start_cyc;
  int                             prev_done_cyc;
  logic                           first_cmd_pending = 1'b0;
  logic                           en_q = 1'b0;
  logic [`NC_FLASH_CMD_W-1:0]     last_cmd = '0;
  logic [`NC_FLASH_CMD_W-1:0]     prev_cmd = '0;
  nand_ctrl_pkg::toggle_code_e    prev_kind = nand_ctrl_pkg::TG_REG_READ;

  initial clk = 1'b0;
  always #20 clk = ~clk;

  nand_ctrl_top u_dut (
    .clk           (clk),
    .rstn          (rstn),
    .start_i       (start),
    .command_i     (command),
    .address_num_i (address_num),
    .r_nb_i        (r_nb),
    .toggle_done_i (toggle_done),
    .toggle_en_o   (toggle_en),
    .cmd_code_o    (cmd_code),
    .cmd_o         (cmd),
    .cmd_en_o      (cmd_en),
    .radr_en_o     (radr_en),
    .cad_sel_o     (cad_sel),
    .amux_sel_o    (amux_sel),
    .bf_reg_addr_o (bf_reg_addr),
    .op_done_o     (op_done)
  );

  tb_nand_flash_model u_flash (
    .clk           (clk),
    .rstn          (rstn),
    .toggle_en_i   (toggle_en),
    .cmd_en_i      (cmd_en),
    .cmd_i         (cmd),
    .toggle_done_o (toggle_done),
    .r_nb_o        (r_nb)
  );

  //////////////////////////////
  // protocol assertions
  //////////////////////////////
  assert property (@(negedge clk) disable iff (!rstn)
    toggle_en && !toggle_done |=> toggle_en && $stable(cmd_code) && $stable(cad_sel)
      && $stable(amux_sel) && $stable(bf_reg_addr))
  else begin
    $display("toggle step dropped or changed before toggle_done_i at cycle %0d", cyc);
    errors++;
  end

  assert property (@(negedge clk) disable iff (!rstn) !r_nb |-> !toggle_en && !op_done)
  else begin
    $display("flash activity while r_nb_i is low at cycle %0d", cyc);
    errors++;
  end

  assert property (@(negedge clk) disable iff (!rstn)
    op_done |=> !op_done && !toggle_en && !cmd_en)
  else begin
    $display("op_done_o was not a single pulse followed by idle at cycle %0d", cyc);
    errors++;
  end

  assert property (@(negedge clk) disable iff (!rstn) cmd_en |=> toggle_en)
  else begin
    $display("cmd_en_o pulse not followed by a toggle step at cycle %0d", cyc);
    errors++;
  end

  assert property (@(negedge clk) disable iff (!rstn)
    radr_en |-> cmd_en && (cmd == `NC_CMD_ERASE_SETUP))
  else begin
    $display("Mismatch cmd_o with radr_en_o: got %h expected %h", cmd, `NC_CMD_ERASE_SETUP);
    errors++;
  end

  //////////////////////////////
  // monitor at mid cycle
  //////////////////////////////
  function automatic step_t pack_step(input nand_ctrl_pkg::toggle_code_e kind,
                                      input logic [11:0] sel,
                                      input logic [7:0] cmd_byte);
    return {kind, sel, cmd_byte};
  endfunction

  function automatic logic [11:0] observed_sel();
    if (cmd_code == nand_ctrl_pkg::TG_REG_READ) begin
      return bf_reg_addr;
    end
    if (cmd_code == nand_ctrl_pkg::TG_ADDR && cad_sel == nand_ctrl_pkg::CAD_ADDR) begin
      return {7'd0, cad_sel, amux_sel};
    end
    return {10'd0, cad_sel};
  endfunction

  always @(negedge clk) begin
    cyc = cyc + 1;
    if (rstn) begin
      if (cmd_en) begin
        last_cmd = cmd;
        cmd_en_cnt++;
        if (first_cmd_pending) begin
          first_cmd_pending = 1'b0;
          assert (cyc - start_cyc == 2) else begin
            $display("first cmd_en_o came %0d cycles after start_i", cyc - start_cyc);
            errors++;
          end
        end
      end
      if (radr_en) radr_cnt++;
      if (op_done) done_cnt++;
      // a new step after a status or erase confirm toggle must respect the wait
      if (toggle_en && !en_q && prev_kind == nand_ctrl_pkg::TG_CMD) begin
        if (prev_cmd == `NC_CMD_STATUS) begin
          assert (cyc - prev_done_cyc >= `NC_TCLR_CYCLES + 1) else begin
            $display("status read began %0d cycles after the 70 toggle", cyc - prev_done_cyc);
            errors++;
          end
        end else if (prev_cmd == `NC_CMD_ERASE_CONFIRM) begin
          assert (cyc - prev_done_cyc >= `NC_TWB_CYCLES + 1) else begin
            $display("toggle began %0d cycles after the D0 toggle", cyc - prev_done_cyc);
            errors++;
          end
        end
      end
      if (toggle_en) begin
        en_cycles++;
        if (toggle_done) begin
          got_q.push_back(pack_step(cmd_code, observed_sel(), last_cmd));
          prev_kind     = cmd_code;
          prev_cmd      = last_cmd;
          prev_done_cyc = cyc;
        end
      end
      en_q = toggle_en && !toggle_done;
    end
  end

  initial begin
    wait (cyc >= MAX_CYCLES);
    $display("timeout: the run was still busy after %0d cycles", cyc);
    $display("ERRORS FOUND");
    $finish;
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  task automatic next_cycle(input int n = 1);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic clear_counts();
    got_q.delete();
    done_cnt   = 0;
    cmd_en_cnt = 0;
    radr_cnt   = 0;
    en_cycles  = 0;
  endtask

  task automatic close_test(input string name, input int err_before);
    tests++;
    if (errors != err_before) failed++;
    $display("test %-18s %s", name, (errors == err_before) ? "ok" : "FAILED");
  endtask

  task automatic expect_status();
    exp_q.push_back(pack_step(nand_ctrl_pkg::TG_CMD, SEL_CMD, `NC_CMD_STATUS));
    exp_q.push_back(pack_step(nand_ctrl_pkg::TG_REG_READ, `NC_STATUS_REG_ADDR, `NC_CMD_STATUS));
  endtask

  task automatic expect_read_id(input int n);
    exp_q.push_back(pack_step(nand_ctrl_pkg::TG_CMD, SEL_CMD, `NC_CMD_READ_ID));
    exp_q.push_back(pack_step(nand_ctrl_pkg::TG_ADDR, SEL_CMD, `NC_CMD_ID_ADDR));
    for (int i = 0; i < n; i++) begin
      exp_q.push_back(pack_step(nand_ctrl_pkg::TG_REG_READ, `NC_ID_REG_BASE + 12'(i),
                                `NC_CMD_ID_ADDR));
    end
  endtask

  task automatic expect_erase(input logic three_rows);
    exp_q.push_back(pack_step(nand_ctrl_pkg::TG_CMD, SEL_CMD, `NC_CMD_ERASE_SETUP));
    exp_q.push_back(pack_step(nand_ctrl_pkg::TG_ADDR, SEL_ROW1, `NC_CMD_ERASE_SETUP));
    exp_q.push_back(pack_step(nand_ctrl_pkg::TG_ADDR, SEL_ROW2, `NC_CMD_ERASE_SETUP));
    if (three_rows) begin
      exp_q.push_back(pack_step(nand_ctrl_pkg::TG_ADDR, SEL_ROW3, `NC_CMD_ERASE_SETUP));
    end
    exp_q.push_back(pack_step(nand_ctrl_pkg::TG_CMD, SEL_CMD, `NC_CMD_ERASE_CONFIRM));
    expect_status();
  endtask

  // one operation from start strobe to op_done with an optional stray start
  task automatic run_op(input string name, input logic [15:0] cmd_val,
                        input logic addr_num, input int exp_radr, input logic stray);
    int err_before;
    err_before = errors;
    clear_counts();
    start             = 1'b1;
    command           = cmd_val;
    address_num       = addr_num;
    start_cyc         = cyc + 1;
    first_cmd_pending = 1'b1;
    next_cycle();
    start = 1'b0;
    if (stray) begin
      while (cmd_en_cnt == 0) next_cycle();
      next_cycle();
      start   = 1'b1;
      command = 16'hFF00;
      next_cycle();
      start = 1'b0;
    end
    while (done_cnt == 0) next_cycle();
    next_cycle(3);
    assert (done_cnt == 1) else begin
      $display("Mismatch op_done_o pulses: got %h expected %h", done_cnt, 1);
      errors++;
    end
    assert (radr_cnt == exp_radr) else begin
      $display("Mismatch radr_en_o pulses: got %h expected %h", radr_cnt, exp_radr);
      errors++;
    end
    assert (got_q.size() == exp_q.size()) else begin
      $display("Mismatch toggle_en_o steps: got %h expected %h", got_q.size(), exp_q.size());
      errors++;
    end
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
      assert (got_q[i] == exp_q[i]) else begin
        $display("Mismatch step %0d {cmd_code_o,sel,cmd_o}: got %h expected %h",
                 i, got_q[i], exp_q[i]);
        errors++;
      end
    end
    exp_q.delete();
    close_test(name, err_before);
  endtask

  initial begin
    int err_before;
    void'($urandom(32'he830_44fa));
    rstn        = 1'b0;
    start       = 1'b0;
    command     = '0;
    address_num = 1'b0;
    clear_counts();
    next_cycle(4);
    rstn = 1'b1;

    err_before = errors;
    assert (!toggle_en && !cmd_en && !radr_en && !op_done) else begin
      $display("Mismatch after reset: toggle_en_o=%h cmd_en_o=%h radr_en_o=%h op_done_o=%h",
               toggle_en, cmd_en, radr_en, op_done);
      errors++;
    end
    close_test("reset state", err_before);

    exp_q.push_back(pack_step(nand_ctrl_pkg::TG_CMD, SEL_CMD, `NC_CMD_RESET));
    run_op("device reset", 16'hFF00, 1'b0, 0, 1'b0);
    expect_status();
    run_op("read status", 16'h7000, 1'b0, 0, 1'b0);
    expect_read_id(4);
    run_op("read id 4 bytes", 16'h9000, 1'b0, 0, 1'b0);
    expect_read_id(6);
    run_op("read id 6 bytes", 16'h9020, 1'b0, 0, 1'b0);
    expect_erase(1'b0);
    run_op("erase 2 rows", 16'h60D0, 1'b0, 1, 1'b0);
    expect_erase(1'b1);
    run_op("erase 3 rows", 16'h60D0, 1'b1, 1, 1'b0);

    // unknown command must leave the flash alone
    err_before = errors;
    clear_counts();
    start   = 1'b1;
    command = 16'h1234;
    next_cycle();
    start = 1'b0;
    next_cycle(20);
    assert (cmd_en_cnt == 0 && en_cycles == 0 && done_cnt == 0) else begin
      $display("unknown command 1234 caused flash activity");
      errors++;
    end
    close_test("unknown command", err_before);

    expect_status();
    run_op("status after unknown", 16'h7000, 1'b0, 0, 1'b0);
    expect_status();
    run_op("start during op", 16'h7000, 1'b0, 0, 1'b1);

    $display("tests run %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- tb_nand_flash_model.sv
`include "nand_ctrl_config.svh"

module tb_nand_flash_model (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       toggle_en_i,
  input  logic                       cmd_en_i,
  input  logic [`NC_FLASH_CMD_W-1:0] cmd_i,
  output logic                       toggle_done_o,
  output logic                       r_nb_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [`NC_FLASH_CMD_W-1:0] last_cmd;

  // command byte behind the current toggle step
  always @(negedge clk) begin
    if (cmd_en_i) begin
      last_cmd = cmd_i;
    end
  end

  task automatic next_cycle(input int unsigned n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    int unsigned delay;
    int unsigned busy;
    toggle_done_o = 1'b0;
    r_nb_o        = 1'b1;
    last_cmd      = '0;
    forever begin
      next_cycle(1);
      if (rstn && toggle_en_i) begin
        delay = $urandom_range(5, 1);
        next_cycle(delay - 1);
        toggle_done_o = 1'b1;
        next_cycle(1);
        toggle_done_o = 1'b0;
        // array busy after erase confirm and a shorter busy after reset
        busy = 0;
        if (last_cmd == `NC_CMD_ERASE_CONFIRM) begin
          busy = $urandom_range(20, 5);
        end else if (last_cmd == `NC_CMD_RESET) begin
          busy = $urandom_range(12, 8);
        end
        if (busy != 0) begin
          // ready/busy falls partway into tWB
          next_cycle(2);
          r_nb_o = 1'b0;
          next_cycle(busy);
          r_nb_o = 1'b1;
        end
      end
    end
  end

endmodule
